/* oled_text.f */
+incdir+logic
logic/oled_bus_pkg.sv
logic/oled_disp_pkg.sv
logic/i2c_writer.sv
logic/oled_scanner.sv
logic/text_renderer.sv
logic/oled_text_top.sv
verif/oled_text_tb.sv

/* Makefile */
# Verilator build and run of the oled text terminal testbench

TOP       ?= oled_text_tb
VERILATOR ?= verilator
BUILD_DIR ?= build
SEED_ARGS ?= +verilator+seed+3993
FILELIST  := oled_text.f

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert \
		-f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	$(BUILD_DIR)/V$(TOP) $(SEED_ARGS)

clean:
	rm -rf $(BUILD_DIR)

/* verif/oled_text_tb.sv */
// testbench for the oled hex terminal, bus slave and frame model, run as the simulation top
`timescale 1ns/100ps
`include "oled_text_cfg.svh"

module oled_text_tb;

localparam int QTR_CYCLES = `MAIN_CLK_HZ / (4 * `SERIAL_CLK_HZ);
localparam int BIT_CYCLES = 4 * QTR_CYCLES;
localparam int BYTE_CYCLES = 9 * BIT_CYCLES;
localparam int NUM_TILES = `NUM_TILES_X * `SCREEN_PAGES;
localparam int FRAME_BYTES = `SCREEN_WIDTH * `SCREEN_PAGES;
// init plus three frames, each with address and control byte, plus 20 percent
localparam int WD_BYTES = oled_disp_pkg::INIT_LEN + 2 + 3 * (FRAME_BYTES + 2);
localparam int WD_CYCLES = WD_BYTES * BYTE_CYCLES / 10 * 12;
localparam int WRITE_GAP = 400;

localparam logic [1:0] EV_START = 2'd0;
localparam logic [1:0] EV_BYTE = 2'd1;
localparam logic [1:0] EV_STOP = 2'd2;

// one bus event seen by the slave, with the model byte at that moment
typedef struct packed {
	logic [1:0] kind;
	logic [7:0] data;
	logic [7:0] expected;
} bus_event_t;

logic                      clk27;
logic                      rst_n;
logic                      text_we;
oled_disp_pkg::tile_addr_u text_addr;
logic [3:0]                text_digit;
logic                      update;
logic                      oled_scl;
logic                      oled_sda_low;
logic                      oled_sda_in;
logic                      bus_error;

integer     seed;
logic       slave_pull;
logic       nack_armed;
int         byte_pos;
bus_event_t events [$];
logic [3:0] shadow [NUM_TILES];
bit         writes_on;
int         live_cycle;
int         ahead_writes;
int         behind_writes;

// open drain line, pad modeled here
assign oled_sda_in = !(oled_sda_low || slave_pull);

oled_text_top i_dut (
	.clk27        (clk27),
	.rst_n        (rst_n),
	.text_we      (text_we),
	.text_addr    (text_addr),
	.text_digit   (text_digit),
	.update       (update),
	.oled_scl     (oled_scl),
	.oled_sda_low (oled_sda_low),
	.oled_sda_in  (oled_sda_in),
	.bus_error    (bus_error)
);

initial begin
	clk27 = 1'b0;
	forever #10 clk27 = ~clk27;
end

// ------------------------------
// helpers
// ------------------------------
task automatic check_eq(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
	if (expected !== actual) begin
		$display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
		$display("=== FAIL ===");
		$fatal(1, "mismatch in %s", name);
	end
endtask

// write strobe drops each cycle unless driven again
task automatic step_cycle();
	@(posedge clk27);
	#2;
	text_we = 1'b0;
endtask

task automatic drive_write(input int idx, input logic [3:0] digit);
	text_we         = 1'b1;
	text_addr.index = 7'(idx);
	text_digit      = digit;
	shadow[idx]     = digit;
endtask

// only tiles well clear of the scan position, so the model stays exact
task automatic try_live_write();
	int         n;
	int         cur;
	int         t;
	logic [3:0] d;
	n   = (byte_pos < 2) ? 0 : byte_pos - 2;
	// tiles follow scan order, 8 bytes each
	cur = n / `TILE_WIDTH;
	t   = $random(seed) & (NUM_TILES - 1);
	d   = 4'($random(seed));
	if (t >= cur + 2) begin
		drive_write(t, d);
		ahead_writes++;
	end else if (t + 2 <= cur) begin
		drive_write(t, d);
		behind_writes++;
	end
endtask

task automatic pop_event(output bus_event_t ev);
	while (events.size() == 0) begin
		step_cycle();
		live_cycle++;
		if (writes_on && (live_cycle % WRITE_GAP == 0))
			try_live_write();
	end
	ev = events.pop_front();
endtask

task automatic expect_event(input logic [1:0] kind, input logic [7:0] data,
		input string name);
	bus_event_t ev;
	pop_event(ev);
	check_eq({name, " event kind"}, 32'(kind), 32'(ev.kind));
	if (kind == EV_BYTE)
		check_eq(name, 32'(data), 32'(ev.data));
endtask

task automatic check_idle(input string name);
	check_eq({name, " scl"}, 1, 32'(oled_scl));
	check_eq({name, " sda_low"}, 0, 32'(oled_sda_low));
	check_eq({name, " bus_error"}, 0, 32'(bus_error));
endtask

// one full frame, optional live writes, optional update drop
task automatic check_frame(input string name, input bit live, input bit last);
	bus_event_t ev;
	expect_event(EV_START, 8'h00, {name, " start"});
	if (last)
		update = 1'b0;
	expect_event(EV_BYTE, `OLED_WRITE_ADDR, {name, " address"});
	expect_event(EV_BYTE, `CTRL_DATA, {name, " control"});
	writes_on = live;
	for (int k = 0; k < FRAME_BYTES; k++) begin
		pop_event(ev);
		check_eq($sformatf("%s byte %0d kind", name, k), 32'(EV_BYTE), 32'(ev.kind));
		check_eq($sformatf("%s byte %0d", name, k), 32'(ev.expected), 32'(ev.data));
	end
	writes_on = 1'b0;
	expect_event(EV_STOP, 8'h00, {name, " stop"});
endtask

// ------------------------------
// bus slave and frame model
// ------------------------------
initial begin : slave_model
	logic       prev_scl;
	logic       prev_sda;
	logic       cur_sda;
	logic [7:0] shift;
	int         bit_cnt;
	int         k;
	int         tile;
	bus_event_t ev;
	prev_scl = 1'b1;
	prev_sda = 1'b1;
	shift    = '0;
	bit_cnt  = 0;
	forever begin
		@(posedge clk27);
		#2;
		cur_sda = !(oled_sda_low || slave_pull);
		ev      = '0;
		if (prev_scl && oled_scl && prev_sda && !cur_sda) begin
			// start
			bit_cnt  = 0;
			byte_pos = 0;
			ev.kind  = EV_START;
			events.push_back(ev);
		end else if (prev_scl && oled_scl && !prev_sda && cur_sda) begin
			// stop
			bit_cnt = 0;
			ev.kind = EV_STOP;
			events.push_back(ev);
		end else if (!prev_scl && oled_scl) begin
			if (bit_cnt < 8)
				shift = {shift[6:0], cur_sda};
			bit_cnt++;
			if (bit_cnt == 8) begin
				ev.kind = EV_BYTE;
				ev.data = shift;
				// pixel bytes after address and control, page outer, hpix inner
				k = byte_pos - 2;
				if (k >= 0 && k < FRAME_BYTES) begin
					tile = (k / `SCREEN_WIDTH) * `NUM_TILES_X
						+ (k % `SCREEN_WIDTH) / `TILE_WIDTH;
					ev.expected = oled_disp_pkg::hex_font[shadow[tile]][k % `TILE_WIDTH];
				end
				events.push_back(ev);
			end
		end else if (prev_scl && !oled_scl) begin
			// ack during the ninth clock
			if (bit_cnt == 8) begin
				slave_pull = !nack_armed;
			end else if (bit_cnt == 9) begin
				slave_pull = 1'b0;
				bit_cnt    = 0;
				byte_pos++;
			end
		end
		prev_scl = oled_scl;
		prev_sda = cur_sda;
	end
end

// ------------------------------
// watchdog
// ------------------------------
initial begin : watchdog
	repeat (WD_CYCLES) @(posedge clk27);
	$display("timeout: the bus did not complete the expected transactions in time");
	$display("=== FAIL ===");
	$fatal(1, "watchdog expired");
end

// ------------------------------
// test sequence
// ------------------------------
initial begin : main_flow
	rst_n         = 1'b0;
	text_we       = 1'b0;
	text_addr     = '0;
	text_digit    = '0;
	update        = 1'b0;
	slave_pull    = 1'b0;
	nack_armed    = 1'b0;
	byte_pos      = 0;
	writes_on     = 1'b0;
	live_cycle    = 0;
	ahead_writes  = 0;
	behind_writes = 0;
	seed          = 32'hf99;
	for (int i = 0; i < NUM_TILES; i++)
		shadow[i] = '0;

	// idle pins in and right after reset
	repeat (8) begin
		step_cycle();
		check_idle("reset idle");
	end
	rst_n = 1'b1;
	repeat (16) begin
		step_cycle();
		check_idle("idle after reset");
	end

	// whole buffer through the page/column view
	for (int p = 0; p < `SCREEN_PAGES; p++) begin
		for (int c = 0; c < `NUM_TILES_X; c++) begin
			text_we           = 1'b1;
			text_addr.pc.page = 3'(p);
			text_addr.pc.col  = 4'(c);
			text_digit        = 4'($random(seed));
			shadow[p * `NUM_TILES_X + c] = text_digit;
			step_cycle();
		end
	end

	// init transaction
	expect_event(EV_START, 8'h00, "init start");
	expect_event(EV_BYTE, `OLED_WRITE_ADDR, "init address");
	expect_event(EV_BYTE, `CTRL_CMD, "init control");
	for (int i = 0; i < oled_disp_pkg::INIT_LEN; i++)
		expect_event(EV_BYTE, oled_disp_pkg::init_cmds[i], $sformatf("init cmd %0d", i));
	expect_event(EV_STOP, 8'h00, "init stop");

	// frame one with writes on both sides of the scanner, frame two shows the rest
	update = 1'b1;
	check_frame("frame one", 1'b1, 1'b0);
	check_eq("writes ahead of scanner", 1, 32'(ahead_writes > 0));
	check_eq("writes behind scanner", 1, 32'(behind_writes > 0));
	check_frame("frame two", 1'b0, 1'b1);

	// bus stays quiet with update low
	repeat (3000 * BIT_CYCLES) step_cycle();
	check_eq("no start with update low", 0, 32'(events.size()));
	check_eq("no error before nack test", 0, 32'(bus_error));

	// refused address byte
	nack_armed = 1'b1;
	update     = 1'b1;
	expect_event(EV_START, 8'h00, "nack start");
	expect_event(EV_BYTE, `OLED_WRITE_ADDR, "nack address");
	check_eq("error before ack", 0, 32'(bus_error));
	expect_event(EV_STOP, 8'h00, "nack stop");
	check_eq("error after nack", 1, 32'(bus_error));
	repeat (200 * BIT_CYCLES) step_cycle();
	check_eq("error held", 1, 32'(bus_error));
	check_eq("bus halted after nack", 0, 32'(events.size()));

	// only reset clears it
	update     = 1'b0;
	nack_armed = 1'b0;
	rst_n      = 1'b0;
	step_cycle();
	check_eq("error cleared by reset", 0, 32'(bus_error));

	$display("=== PASS ===");
	$finish;
end

endmodule

/* logic/oled_text_top.sv */
// top level of the oled hex terminal, joins bus writer, frame scanner and text renderer
`timescale 1ns/100ps

module oled_text_top (
	input  logic                      clk27,
	input  logic                      rst_n,
	// text buffer write port
	input  logic                      text_we,
	input  oled_disp_pkg::tile_addr_u text_addr,
	input  logic [3:0]                text_digit,
	// frames run while high
	input  logic                      update,
	// bus pins, pad outside
	output logic                      oled_scl,
	output logic                      oled_sda_low,
	input  logic                      oled_sda_in,
	output logic                      bus_error
);

oled_bus_pkg::bus_req_t  bus_req;
oled_bus_pkg::bus_stat_t bus_stat;
oled_disp_pkg::pix_pos_t pix_pos;
logic [7:0]              pixels;

// ------------------------------
// serial bus
// ------------------------------
i2c_writer i_writer (
	.clk27   (clk27),
	.rst_n   (rst_n),
	.req     (bus_req),
	.stat    (bus_stat),
	.scl     (oled_scl),
	.sda_low (oled_sda_low),
	.sda_in  (oled_sda_in)
);

// ------------------------------
// display side
// ------------------------------
oled_scanner i_scanner (
	.clk27  (clk27),
	.rst_n  (rst_n),
	.update (update),
	.stat   (bus_stat),
	.req    (bus_req),
	.pos    (pix_pos),
	.pixels (pixels)
);

text_renderer i_renderer (
	.clk27  (clk27),
	.rst_n  (rst_n),
	.we     (text_we),
	.waddr  (text_addr),
	.wdigit (text_digit),
	.pos    (pix_pos),
	.pixels (pixels)
);

assign bus_error = bus_stat.error;

endmodule

/* logic/text_renderer.sv */
// hex text buffer with write port, turns a pixel position into an 8-pixel column byte
`timescale 1ns/100ps
`include "oled_text_cfg.svh"

module text_renderer (
	input  logic                      clk27,
	input  logic                      rst_n,
	input  logic                      we,
	input  oled_disp_pkg::tile_addr_u waddr,
	input  logic [3:0]                wdigit,
	input  oled_disp_pkg::pix_pos_t   pos,
	output logic [7:0]                pixels
);

localparam int NUM_TILES = `NUM_TILES_X * `SCREEN_PAGES;
localparam int COL_W = $clog2(`NUM_TILES_X);
localparam int TPIX_W = $clog2(`TILE_WIDTH);

// one hex digit per tile
logic [3:0]                digits [NUM_TILES];
oled_disp_pkg::tile_addr_u raddr;
logic [3:0]                cur_digit;
logic [TPIX_W-1:0]         tile_pix;

// ------------------------------
// text buffer
// ------------------------------
// blank screen of zeros after reset
always_ff @(posedge clk27 or negedge rst_n) begin
	if (!rst_n) begin
		for (int i = 0; i < NUM_TILES; i++)
			digits[i] <= '0;
	end else if (we) begin
		digits[waddr.index] <= wdigit;
	end
end

// ------------------------------
// font lookup
// ------------------------------
// tile from page and column, read back as linear index
always_comb begin
	raddr.pc.page = pos.page;
	raddr.pc.col  = COL_W'(pos.hpix / `TILE_WIDTH);
end

// column inside the tile
assign tile_pix  = TPIX_W'(pos.hpix % `TILE_WIDTH);
assign cur_digit = digits[raddr.index];
assign pixels    = oled_disp_pkg::hex_font[cur_digit][tile_pix];

endmodule

/* logic/oled_scanner.sv */
// init and frame sequencer, feeds control, command and pixel bytes to the bus writer
`timescale 1ns/100ps
`include "oled_text_cfg.svh"

module oled_scanner (
	input  logic                    clk27,
	input  logic                    rst_n,
	input  logic                    update,
	input  oled_bus_pkg::bus_stat_t stat,
	output oled_bus_pkg::bus_req_t  req,
	output oled_disp_pkg::pix_pos_t pos,
	input  logic [7:0]              pixels
);

localparam int IDX_W = $clog2(oled_disp_pkg::INIT_LEN);
localparam int HPIX_LAST = `SCREEN_WIDTH - 1;
localparam int PAGE_LAST = `SCREEN_PAGES - 1;

typedef enum logic [1:0] {
	PH_INIT,
	PH_WAIT,
	PH_FRAME
} phase_t;

phase_t           phase;
logic             enable;
// control byte still pending
logic             first;
logic [IDX_W-1:0] init_idx;

// ------------------------------
// phase and counters
// ------------------------------
always_ff @(posedge clk27 or negedge rst_n) begin
	if (!rst_n) begin
		phase    <= PH_INIT;
		enable   <= 1'b0;
		first    <= 1'b1;
		init_idx <= '0;
		pos      <= '0;
	end else begin
		case (phase)
		PH_INIT: begin
			// first cycle out of reset opens the init transaction
			if (!enable) begin
				enable <= 1'b1;
			end else if (stat.next_word) begin
				if (first) begin
					first <= 1'b0;
				end else if (init_idx == IDX_W'(oled_disp_pkg::INIT_LEN - 1)) begin
					enable   <= 1'b0;
					first    <= 1'b1;
					init_idx <= '0;
					phase    <= PH_WAIT;
				end else begin
					init_idx <= init_idx + 1'b1;
				end
			end
		end
		// next frame once the bus is free again
		PH_WAIT: begin
			if (stat.ready && update) begin
				enable <= 1'b1;
				phase  <= PH_FRAME;
			end
		end
		PH_FRAME: begin
			if (stat.next_word) begin
				if (first) begin
					first <= 1'b0;
				end else if (pos.hpix == 7'(HPIX_LAST)) begin
					// end of page
					pos.hpix <= '0;
					pos.page <= pos.page + 1'b1;
					if (pos.page == 3'(PAGE_LAST)) begin
						enable <= 1'b0;
						first  <= 1'b1;
						phase  <= PH_WAIT;
					end
				end else begin
					pos.hpix <= pos.hpix + 1'b1;
				end
			end
		end
		default: phase <= PH_WAIT;
		endcase
	end
end

// ------------------------------
// byte select
// ------------------------------
// renderer is combinational, pixels follow pos in the same cycle
always_comb begin
	req.enable = enable;
	if (first)
		req.data = (phase == PH_FRAME) ? `CTRL_DATA : `CTRL_CMD;
	else if (phase == PH_INIT)
		req.data = oled_disp_pkg::init_cmds[init_idx];
	else
		req.data = pixels;
end

// column wrap always comes with a page step
hpix_wrap_page: assert property (@(posedge clk27) disable iff (!rst_n)
	(pos.hpix == '0 && $past(pos.hpix) == 7'(HPIX_LAST)) |->
		pos.page == 3'($past(pos.page) + 1'b1));

endmodule

/* logic/i2c_writer.sv */
// write only two-wire bus master, sends start, address, data bytes and stop on request
`timescale 1ns/100ps
`include "oled_text_cfg.svh"

module i2c_writer (
	input  logic                    clk27,
	input  logic                    rst_n,
	input  oled_bus_pkg::bus_req_t  req,
	output oled_bus_pkg::bus_stat_t stat,
	output logic                    scl,
	output logic                    sda_low,
	input  logic                    sda_in
);

// cycles per quarter of a bit
localparam int QTR_CYCLES = `MAIN_CLK_HZ / (4 * `SERIAL_CLK_HZ);
localparam int QCTR_W = $clog2(QTR_CYCLES);

typedef enum logic [2:0] {
	ST_IDLE,
	ST_START,
	ST_ADDR,
	ST_DATA,
	ST_ACK,
	ST_STOP,
	ST_HOLD
} state_t;

state_t            state;
logic [QCTR_W-1:0] qctr;
logic [1:0]        quarter;
logic [2:0]        bcnt;
logic [7:0]        shreg;
logic              nack;
logic              next_word;
logic              error;
logic              tick;
logic              bit_end;
logic              scl_nx;
logic              sda_low_nx;

assign tick = (qctr == QCTR_W'(QTR_CYCLES - 1));
assign bit_end = tick && (quarter == 2'd3);

// ------------------------------
// bit sequencer
// ------------------------------
always_ff @(posedge clk27 or negedge rst_n) begin
	if (!rst_n) begin
		state     <= ST_IDLE;
		qctr      <= '0;
		quarter   <= '0;
		bcnt      <= '0;
		nack      <= 1'b0;
		next_word <= 1'b0;
		error     <= 1'b0;
	end else begin
		next_word <= 1'b0;
		if (state == ST_IDLE) begin
			// hold the quarter phase so a start is aligned
			qctr    <= '0;
			quarter <= '0;
			bcnt    <= '0;
			// a refused slave halts the bus until reset
			if (req.enable && !error)
				state <= ST_START;
		end else begin
			qctr <= tick ? '0 : qctr + 1'b1;
			if (tick)
				quarter <= quarter + 1'b1;
			// sample ack in the middle of the high phase
			if (state == ST_ACK && tick && quarter == 2'd1)
				nack <= sda_in;
			if (bit_end) begin
				case (state)
				ST_START: state <= ST_ADDR;
				ST_ADDR, ST_DATA: begin
					bcnt <= bcnt + 1'b1;
					if (bcnt == 3'd7)
						state <= ST_ACK;
				end
				ST_ACK: begin
					if (nack) begin
						error <= 1'b1;
						state <= ST_STOP;
					end else if (req.enable) begin
						next_word <= 1'b1;
						state     <= ST_DATA;
					end else begin
						state <= ST_STOP;
					end
				end
				ST_STOP: state <= ST_HOLD;
				// bus free time, two bits
				ST_HOLD: begin
					bcnt <= bcnt + 1'b1;
					if (bcnt == 3'd1)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
				endcase
			end
		end
	end
end

// shifter, msb first
always_ff @(posedge clk27) begin
	if (state == ST_IDLE)
		shreg <= `OLED_WRITE_ADDR;
	else if (bit_end && (state == ST_ADDR || state == ST_DATA))
		shreg <= {shreg[6:0], 1'b0};
	else if (bit_end && state == ST_ACK && req.enable)
		shreg <= req.data;
end

// ------------------------------
// pin levels
// ------------------------------
// scl low in quarters 0 and 3 of a data bit, sda moves at quarter 0
always_comb begin
	scl_nx     = 1'b1;
	sda_low_nx = 1'b0;
	case (state)
	ST_START: begin
		scl_nx     = (quarter != 2'd3);
		sda_low_nx = (quarter != 2'd0);
	end
	ST_ADDR, ST_DATA: begin
		scl_nx     = (quarter == 2'd1) || (quarter == 2'd2);
		sda_low_nx = ~shreg[7];
	end
	// sda released for the slave
	ST_ACK: scl_nx = (quarter == 2'd1) || (quarter == 2'd2);
	ST_STOP: begin
		scl_nx     = (quarter != 2'd0);
		sda_low_nx = (quarter == 2'd0) || (quarter == 2'd1);
	end
	default: ;
	endcase
end

always_ff @(posedge clk27 or negedge rst_n) begin
	if (!rst_n) begin
		scl     <= 1'b1;
		sda_low <= 1'b0;
	end else begin
		scl     <= scl_nx;
		sda_low <= sda_low_nx;
	end
end

assign stat.ready     = (state == ST_IDLE);
assign stat.next_word = next_word;
assign stat.error     = error;

// sda only moves under a steady clock, and only under high scl for start or stop
sda_vs_scl: assert property (@(posedge clk27) disable iff (!rst_n)
	$changed(sda_low) |-> $stable(scl) &&
		(!scl || $past(state) == ST_START || $past(state) == ST_STOP));

// a word request never shows up on an idle bus
no_word_when_ready: assert property (@(posedge clk27) disable iff (!rst_n)
	!(stat.next_word && stat.ready));

endmodule

/* logic/oled_disp_pkg.sv */
// display side types, hex font and controller init list used by scanner, renderer and bench
`include "oled_text_cfg.svh"

package oled_disp_pkg;

	// page in the upper bits so the pair reads as page*16 + col
	typedef struct packed {
		logic [2:0] page;
		logic [3:0] col;
	} tile_pc_t;

	// one tile address, seen as buffer index or as page/column
	typedef union packed {
		logic [6:0] index;
		tile_pc_t   pc;
	} tile_addr_u;

	// pixel column position on the screen
	typedef struct packed {
		logic [2:0] page;
		logic [6:0] hpix;
	} pix_pos_t;

	// ------------------------------
	// hex glyphs
	// ------------------------------
	// 8 column bytes per glyph, bit 0 is the top row
	localparam logic [7:0] hex_font [16][8] = '{
		'{8'h00, 8'h3e, 8'h51, 8'h49, 8'h45, 8'h3e, 8'h00, 8'h00},
		'{8'h00, 8'h00, 8'h42, 8'h7f, 8'h40, 8'h00, 8'h00, 8'h00},
		'{8'h00, 8'h42, 8'h61, 8'h51, 8'h49, 8'h46, 8'h00, 8'h00},
		'{8'h00, 8'h21, 8'h41, 8'h45, 8'h4b, 8'h31, 8'h00, 8'h00},
		'{8'h00, 8'h18, 8'h14, 8'h12, 8'h7f, 8'h10, 8'h00, 8'h00},
		'{8'h00, 8'h27, 8'h45, 8'h45, 8'h45, 8'h39, 8'h00, 8'h00},
		'{8'h00, 8'h3c, 8'h4a, 8'h49, 8'h49, 8'h30, 8'h00, 8'h00},
		'{8'h00, 8'h01, 8'h71, 8'h09, 8'h05, 8'h03, 8'h00, 8'h00},
		'{8'h00, 8'h36, 8'h49, 8'h49, 8'h49, 8'h36, 8'h00, 8'h00},
		'{8'h00, 8'h06, 8'h49, 8'h49, 8'h29, 8'h1e, 8'h00, 8'h00},
		'{8'h00, 8'h7e, 8'h11, 8'h11, 8'h11, 8'h7e, 8'h00, 8'h00},
		'{8'h00, 8'h7f, 8'h49, 8'h49, 8'h49, 8'h36, 8'h00, 8'h00},
		'{8'h00, 8'h3e, 8'h41, 8'h41, 8'h41, 8'h22, 8'h00, 8'h00},
		'{8'h00, 8'h7f, 8'h41, 8'h41, 8'h22, 8'h1c, 8'h00, 8'h00},
		'{8'h00, 8'h7f, 8'h49, 8'h49, 8'h49, 8'h41, 8'h00, 8'h00},
		'{8'h00, 8'h7f, 8'h09, 8'h09, 8'h01, 8'h01, 8'h00, 8'h00}
	};

	// ------------------------------
	// controller setup
	// ------------------------------
	localparam int INIT_LEN = 8;

	// horizontal addressing, then full column range, then full page range
	localparam logic [7:0] init_cmds [INIT_LEN] = '{
		8'h20, 8'h00,
		8'h21, 8'h00, 8'(`SCREEN_WIDTH - 1),
		8'h22, 8'h00, 8'(`SCREEN_PAGES - 1)
	};

endpackage

/* logic/oled_bus_pkg.sv */
// bus side types shared by the serial writer, the scanner and the top level
package oled_bus_pkg;

	// ------------------------------
	// scanner to writer
	// ------------------------------
	// enable is held for the whole transaction
	// data is the byte the writer latches next
	typedef struct packed {
		logic       enable;
		logic [7:0] data;
	} bus_req_t;

	// ------------------------------
	// writer to scanner
	// ------------------------------
	// ready high only while the bus is idle
	// next_word pulses once per latched data byte
	// error sticks until reset
	typedef struct packed {
		logic ready;
		logic next_word;
		logic error;
	} bus_stat_t;

endpackage

/* logic/oled_text_cfg.svh */
// shared build constants for the oled text terminal, pulled in with `include by rtl and bench
`ifndef OLED_TEXT_CFG_SVH
`define OLED_TEXT_CFG_SVH

// ------------------------------
// clocks
// ------------------------------
`define MAIN_CLK_HZ 50000000
`define SERIAL_CLK_HZ 400000

// ------------------------------
// screen and tile geometry
// ------------------------------
// tile height is one page
`define SCREEN_WIDTH 128
`define SCREEN_PAGES 8
`define TILE_WIDTH 8
`define NUM_TILES_X 16

// ------------------------------
// bus addressing
// ------------------------------
`define OLED_WRITE_ADDR 8'h78
// control byte, command stream follows
`define CTRL_CMD 8'h00
// control byte, display data follows
`define CTRL_DATA 8'h40

`endif
